// File: tb.f
design/rom_pkg.sv
design/download_decoder.sv
design/prog_writer.sv
design/rom_slot_arbiter.sv
design/rom_sdram_top.sv
verification/sdram_model.sv
verification/rom_sdram_checker.sv
verification/rom_sdram_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line in its output
verilator --binary --assert -Wno-fatal --top-module rom_sdram_tb -f tb.f -o rom_sdram_sim &&
    ./obj_dir/rom_sdram_sim | tee /dev/stderr | grep -qx "=== PASS ===" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// File: verification/rom_sdram_tb.sv
// testbench for the rom sdram frame that downloads an image and reads it back through both slots
`timescale 1ns/100ps

module rom_sdram_tb;
    import rom_pkg::*;

    localparam int unsigned CPU_LEN    = 64;
    localparam int unsigned SND_LEN    = 32;
    localparam int unsigned TILE_LEN   = 64;
    localparam int unsigned SND_OFFSET = 'h100000;
    localparam int unsigned SND_BASE   = 1 + CPU_LEN;
    localparam int unsigned TILE_BASE  = SND_BASE + SND_LEN;
    localparam int unsigned IMG_LEN    = TILE_BASE + TILE_LEN; // game byte included
    localparam int unsigned NUM_PAIRS  = 16;
    localparam int unsigned NUM_READS  = NUM_PAIRS * 2 + 3;
    localparam int unsigned WATCHDOG_CYCLES = IMG_LEN * 12 + NUM_READS * 20 + 200;

    logic        CLK = 1'b0;
    logic        reset;
    logic        ioctl_wr;
    logic [25:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        downloading;
    logic [7:0]  game;
    prog_wr_t    prog;
    logic        prog_we;
    logic        prog_rdy;
    logic        cpu_cs;
    logic [16:0] cpu_addr;
    logic        cpu_ok;
    logic [15:0] cpu_dout;
    logic        snd_cs;
    logic [14:0] snd_addr;
    logic        snd_ok;
    logic [7:0]  snd_dout;
    logic        sdram_req;
    logic [21:0] sdram_addr;
    logic        sdram_ack;
    logic        data_rdy;
    logic [15:0] data_read;

    logic [15:0] exp_mem [logic [23:0]]; // expected words keyed by {bank, word address}
    int unsigned req_count = 0;
    logic        req_prev = 1'b0;
    logic [21:0] req_addrs [$]; // word address of each new request
    int unsigned tests = 0;
    int unsigned checks = 0;
    int unsigned errors = 0;

    rom_sdram_top #(
        .CPU_LEN    (CPU_LEN),
        .SND_LEN    (SND_LEN),
        .TILE_LEN   (TILE_LEN),
        .SND_OFFSET (SND_OFFSET)
    ) rom_sdram_top_inst (
        .CLK (CLK), .reset (reset),
        .ioctl_wr (ioctl_wr), .ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout),
        .downloading (downloading), .game (game),
        .prog (prog), .prog_we (prog_we), .prog_rdy (prog_rdy),
        .cpu_cs (cpu_cs), .cpu_addr (cpu_addr), .cpu_ok (cpu_ok), .cpu_dout (cpu_dout),
        .snd_cs (snd_cs), .snd_addr (snd_addr), .snd_ok (snd_ok), .snd_dout (snd_dout),
        .sdram_req (sdram_req), .sdram_addr (sdram_addr), .sdram_ack (sdram_ack),
        .data_rdy (data_rdy), .data_read (data_read)
    );

    sdram_model sdram_model_inst (
        .CLK (CLK), .reset (reset),
        .prog (prog), .prog_we (prog_we), .prog_rdy (prog_rdy),
        .sdram_req (sdram_req), .sdram_addr (sdram_addr), .sdram_ack (sdram_ack),
        .data_rdy (data_rdy), .data_read (data_read)
    );

    always #4 CLK = ~CLK;

    // each read request is a separate rise since the arbiter idles in between
    always @(posedge CLK) begin
        req_prev <= sdram_req;
        if (sdram_req && !req_prev) begin
            req_count <= req_count + 1;
            req_addrs.push_back(sdram_addr);
        end
    end

    task automatic compare_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_word(input string name, input logic [15:0] exp,
                                input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_addr(input string name, input logic [21:0] exp,
                                input logic [21:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_region(input string name, input region_e exp, input region_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic compare_prog(input string name, input prog_wr_t exp, input prog_wr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic region_e expected_region(input int unsigned a);
        if (a == 0) return REGION_GAME;
        if (a < SND_BASE) return REGION_CPU;
        if (a < TILE_BASE) return REGION_SND;
        if (a < IMG_LEN) return REGION_TILE;
        return REGION_NONE;
    endfunction

    // region offset to word address and the lane from the download address parity
    function automatic prog_wr_t expected_write(input int unsigned a, input logic [7:0] data);
        prog_wr_t    wr;
        int unsigned offs;
        offs = a - 1;
        if (a >= TILE_BASE) offs = a - TILE_BASE;
        else if (a >= SND_BASE) offs = a - SND_BASE + SND_OFFSET;
        wr.addr = 22'(offs >> 1);
        wr.data = {data, data};
        wr.mask = a[0] ? 2'b01 : 2'b10;
        wr.bank = (a >= TILE_BASE) ? BANK_GFX : BANK_PRG;
        return wr;
    endfunction

    function automatic logic [15:0] word_at(input logic [1:0] bank, input logic [21:0] addr);
        return exp_mem.exists({bank, addr}) ? exp_mem[{bank, addr}] : 16'h0;
    endfunction

    function automatic void store_expected(input prog_wr_t wr);
        logic [15:0] word;
        word = word_at(wr.bank, wr.addr);
        if (wr.mask[1]) word[15:8] = wr.data[15:8];
        if (wr.mask[0]) word[7:0] = wr.data[7:0];
        exp_mem[{wr.bank, wr.addr}] = word;
    endfunction

    task automatic finish_test(input string name, input int unsigned errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // one strobe and the decoded region one edge later
    task automatic send_byte(input int unsigned a, input logic [7:0] data, input string name);
        @(negedge CLK);
        ioctl_wr   = 1'b1;
        ioctl_addr = 26'(a);
        ioctl_dout = data;
        @(negedge CLK);
        ioctl_wr = 1'b0;
        compare_region(name, expected_region(a), rom_sdram_top_inst.dl_item.region);
    endtask

    task automatic expect_no_write(input string name);
        repeat (3) begin
            @(negedge CLK);
            compare_bit(name, 1'b0, prog_we);
        end
    endtask

    task automatic read_slots(input logic use_cpu, input logic [16:0] ca, input logic use_snd,
                              input logic [14:0] sa, input string name);
        logic        cpu_done;
        logic        snd_done;
        logic [15:0] word;
        cpu_done = !use_cpu;
        snd_done = !use_snd;
        @(negedge CLK);
        cpu_cs   = use_cpu;
        cpu_addr = ca;
        snd_cs   = use_snd;
        snd_addr = sa;
        while (!(cpu_done && snd_done)) begin
            @(negedge CLK);
            if (!cpu_done && cpu_ok) begin
                cpu_done = 1'b1;
                compare_word(name, word_at(BANK_PRG, 22'(ca)), cpu_dout);
            end
            if (!snd_done && snd_ok) begin
                snd_done = 1'b1;
                word = word_at(BANK_PRG, 22'(SND_OFFSET / 2 + sa / 2));
                compare_byte(name, sa[0] ? word[7:0] : word[15:8], snd_dout); // even is high
            end
        end
        cpu_cs = 1'b0;
        snd_cs = 1'b0;
        @(negedge CLK); // ok drops here
    endtask

    task automatic test_reset();
        int unsigned err0;
        err0 = errors;
        compare_bit("reset prog_we", 1'b0, prog_we);
        compare_bit("reset sdram_req", 1'b0, sdram_req);
        compare_bit("reset cpu_ok", 1'b0, cpu_ok);
        compare_bit("reset snd_ok", 1'b0, snd_ok);
        compare_byte("reset game", 8'h00, game);
        finish_test("reset", err0);
    endtask

    task automatic test_game();
        int unsigned err0;
        err0 = errors;
        send_byte(0, 8'ha5, "game_byte");
        expect_no_write("game_byte prog_we");
        compare_byte("game_byte", 8'ha5, game);
        finish_test("game_byte", err0);
    endtask

    task automatic test_image();
        int unsigned err0;
        prog_wr_t    wr;
        logic [7:0]  data;
        err0 = errors;
        for (int unsigned a = 1; a < IMG_LEN; a++) begin
            data = 8'($urandom);
            send_byte(a, data, "image_download");
            while (!prog_we) @(negedge CLK);
            wr = expected_write(a, data);
            compare_prog("image_download", wr, prog);
            store_expected(wr);
            while (prog_we) @(negedge CLK);
        end
        foreach (exp_mem[key]) begin
            compare_word("image_download memory", exp_mem[key], sdram_model_inst.mem[key]);
        end
        finish_test("image_download", err0);
    endtask

    task automatic test_out_of_range();
        int unsigned err0;
        err0 = errors;
        send_byte(IMG_LEN, 8'h3c, "out_of_range");
        expect_no_write("out_of_range prog_we");
        finish_test("out_of_range", err0);
    endtask

    task automatic test_reads();
        int unsigned err0;
        int unsigned mode;
        logic [16:0] ca;
        logic [14:0] sa;
        err0 = errors;
        for (int unsigned i = 0; i < NUM_PAIRS; i++) begin
            mode = (i == 0) ? 2 : $urandom_range(2, 0); // 0 cpu, 1 sound, 2 both
            ca   = 17'($urandom_range(CPU_LEN / 2 - 1, 0));
            sa   = 15'($urandom_range(SND_LEN - 1, 0));
            req_addrs.delete();
            read_slots(mode != 1, ca, mode != 0, sa, "slot_reads");
            if (i == 0) begin
                // both caches are empty here and the cpu miss goes first
                compare_word("slot_reads request count", 16'd2, 16'(req_addrs.size()));
                if (req_addrs.size() == 2) begin
                    compare_addr("slot_reads cpu request", 22'(ca), req_addrs[0]);
                    compare_addr("slot_reads sound request",
                                 22'(SND_OFFSET / 2 + sa / 2), req_addrs[1]);
                end
            end
        end
        finish_test("slot_reads", err0);
    endtask

    task automatic test_cache();
        int unsigned err0;
        int unsigned reqs;
        logic [16:0] ca;
        err0 = errors;
        ca = 17'($urandom_range(CPU_LEN / 2 - 1, 0));
        read_slots(1'b1, ca, 1'b0, 15'd0, "cache_hit");
        reqs = req_count;
        read_slots(1'b1, ca, 1'b0, 15'd0, "cache_hit");
        compare_word("cache_hit request count", 16'(reqs), 16'(req_count));
        @(negedge CLK);
        downloading = 1'b1; // drops both entries
        repeat (2) @(negedge CLK);
        downloading = 1'b0;
        read_slots(1'b1, ca, 1'b0, 15'd0, "cache_refetch");
        compare_word("cache_refetch request count", 16'(reqs + 1), 16'(req_count));
        compare_addr("cache_refetch request address", 22'(ca), req_addrs[$]);
        finish_test("cache", err0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(31));
        reset       = 1'b1;
        ioctl_wr    = 1'b0;
        ioctl_addr  = 26'd0;
        ioctl_dout  = 8'h00;
        downloading = 1'b0;
        cpu_cs      = 1'b0;
        cpu_addr    = 17'd0;
        snd_cs      = 1'b0;
        snd_addr    = 15'd0;
        repeat (10) @(negedge CLK);
        reset = 1'b0;
        test_reset();
        downloading = 1'b1;
        test_game();
        test_image();
        test_out_of_range();
        downloading = 1'b0;
        test_reads();
        test_cache();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verification/rom_sdram_checker.sv
// protocol checks on the sdram read request, the write strobe and the slot ok flags
`timescale 1ns/100ps

module rom_sdram_checker (
    input logic        CLK,
    input logic        reset,
    input logic        ioctl_wr,
    input logic        prog_we,
    input logic        sdram_req,
    input logic [21:0] sdram_addr,
    input logic        sdram_ack,
    input logic        cpu_ok,
    input logic        snd_ok
);

    // request and address held until the controller takes them
    req_held: assert property (@(posedge CLK) disable iff (reset)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else $error("sdram_req dropped or sdram_addr moved before sdram_ack");

    we_after_strobe: assert property (@(posedge CLK) disable iff (reset)
        $rose(prog_we) |-> $past(ioctl_wr, 2))
        else $error("prog_we rose without a download strobe two cycles before");

    ok_low_in_reset: assert property (@(posedge CLK) reset |=> !cpu_ok && !snd_ok)
        else $error("slot ok flag high during reset");

endmodule

bind rom_sdram_top rom_sdram_checker rom_sdram_checker_inst (
    .CLK        (CLK),
    .reset      (reset),
    .ioctl_wr   (ioctl_wr),
    .prog_we    (prog_we),
    .sdram_req  (sdram_req),
    .sdram_addr (sdram_addr),
    .sdram_ack  (sdram_ack),
    .cpu_ok     (cpu_ok),
    .snd_ok     (snd_ok)
);

// File: verification/sdram_model.sv
// behavioral sdram, masked word writes with a ready pulse and bank 0 reads with ack and data
`timescale 1ns/100ps

module sdram_model (
    input  logic              CLK,
    input  logic              reset,
    input  rom_pkg::prog_wr_t prog,
    input  logic              prog_we,
    output logic              prog_rdy,
    input  logic              sdram_req,
    input  logic [21:0]       sdram_addr,
    output logic              sdram_ack,
    output logic              data_rdy,
    output logic [15:0]       data_read
);
    import rom_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACK,
        RD_DATA
    } rd_state_e;

    logic [15:0] mem [logic [23:0]]; // sparse, keyed by {bank, word address}
    logic        wr_busy;
    int unsigned wr_count;
    rd_state_e   rd_state;
    int unsigned rd_count;
    logic [21:0] rd_addr;
    logic [15:0] word;

    always @(posedge CLK) begin
        prog_rdy  <= 1'b0; // all three are single cycle pulses
        sdram_ack <= 1'b0;
        data_rdy  <= 1'b0;
        if (reset) begin
            wr_busy  <= 1'b0;
            rd_state <= RD_IDLE;
        end else begin
            if (!wr_busy && prog_we && !prog_rdy) begin
                wr_busy  <= 1'b1;
                wr_count <= $urandom_range(4, 1);
            end else if (wr_busy && wr_count > 1) begin
                wr_count <= wr_count - 1;
            end else if (wr_busy) begin
                word = mem.exists({prog.bank, prog.addr}) ? mem[{prog.bank, prog.addr}] : 16'h0;
                if (prog.mask[1]) word[15:8] = prog.data[15:8];
                if (prog.mask[0]) word[7:0] = prog.data[7:0];
                mem[{prog.bank, prog.addr}] = word;
                prog_rdy <= 1'b1;
                wr_busy  <= 1'b0;
            end

            case (rd_state)
                RD_IDLE: begin
                    if (sdram_req) begin
                        rd_addr  <= sdram_addr;
                        rd_count <= $urandom_range(3, 1);
                        rd_state <= RD_ACK;
                    end
                end
                RD_ACK: begin
                    if (rd_count > 1) begin
                        rd_count <= rd_count - 1;
                    end else begin
                        sdram_ack <= 1'b1;
                        rd_count  <= $urandom_range(4, 1); // data delay after ack
                        rd_state  <= RD_DATA;
                    end
                end
                default: begin
                    if (rd_count > 1) begin
                        rd_count <= rd_count - 1;
                    end else begin
                        data_rdy  <= 1'b1;
                        data_read <= mem.exists({BANK_PRG, rd_addr}) ?
                                     mem[{BANK_PRG, rd_addr}] : 16'h0;
                        rd_state  <= RD_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/rom_sdram_top.sv
// rom side of the sdram frame, download decode and write stages plus the bank 0 read arbiter
`timescale 1ns/100ps

module rom_sdram_top #(
    parameter int unsigned CPU_LEN    = 'h40000,
    parameter int unsigned SND_LEN    = 'h8000,
    parameter int unsigned TILE_LEN   = 'h200000,
    parameter int unsigned SND_OFFSET = 'h100000
) (
    input  logic              CLK,
    input  logic              reset,

    // download port
    input  logic              ioctl_wr,
    input  logic [25:0]       ioctl_addr,
    input  logic [7:0]        ioctl_dout,
    input  logic              downloading,
    output logic [7:0]        game,

    // sdram write
    output rom_pkg::prog_wr_t prog,
    output logic              prog_we,
    input  logic              prog_rdy,

    // main cpu slot
    input  logic              cpu_cs,
    input  logic [16:0]       cpu_addr,
    output logic              cpu_ok,
    output logic [15:0]       cpu_dout,

    // sound cpu slot
    input  logic              snd_cs,
    input  logic [14:0]       snd_addr,
    output logic              snd_ok,
    output logic [7:0]        snd_dout,

    // bank 0 read port
    output logic              sdram_req,
    output logic [21:0]       sdram_addr,
    input  logic              sdram_ack,
    input  logic              data_rdy,
    input  logic [15:0]       data_read
);
    import rom_pkg::*;

    dl_item_t dl_item; // decoder to writer

    download_decoder #(
        .CPU_LEN  (CPU_LEN),
        .SND_LEN  (SND_LEN),
        .TILE_LEN (TILE_LEN)
    ) download_decoder_inst (
        .CLK        (CLK),
        .reset      (reset),
        .ioctl_wr   (ioctl_wr),
        .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout),
        .item       (dl_item),
        .game       (game)
    );

    prog_writer #(
        .SND_OFFSET (SND_OFFSET)
    ) prog_writer_inst (
        .CLK         (CLK),
        .reset       (reset),
        .item        (dl_item),
        .downloading (downloading),
        .prog_rdy    (prog_rdy),
        .prog        (prog),
        .prog_we     (prog_we)
    );

    rom_slot_arbiter #(
        .SND_OFFSET (SND_OFFSET)
    ) rom_slot_arbiter_inst (
        .CLK         (CLK),
        .reset       (reset),
        .downloading (downloading),
        .cpu_cs      (cpu_cs),
        .cpu_addr    (cpu_addr),
        .cpu_ok      (cpu_ok),
        .cpu_dout    (cpu_dout),
        .snd_cs      (snd_cs),
        .snd_addr    (snd_addr),
        .snd_ok      (snd_ok),
        .snd_dout    (snd_dout),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read)
    );

endmodule

// File: design/rom_slot_arbiter.sv
// bank 0 read arbiter, cached cpu word slot and sound byte slot sharing one sdram port
`timescale 1ns/100ps

module rom_slot_arbiter #(
    parameter int unsigned SND_OFFSET = 'h100000
) (
    input  logic        CLK,
    input  logic        reset,
    input  logic        downloading,

    input  logic        cpu_cs,
    input  logic [16:0] cpu_addr,   // word address
    output logic        cpu_ok,
    output logic [15:0] cpu_dout,

    input  logic        snd_cs,
    input  logic [14:0] snd_addr,   // byte address
    output logic        snd_ok,
    output logic [7:0]  snd_dout,

    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [15:0] data_read
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_e;

    localparam logic [21:0] SND_WORD_BASE = 22'(SND_OFFSET >> 1);

    arb_state_e  state;
    logic        owner_snd; // slot that owns the request in flight
    logic        snd_wait;  // sound lost a grant and goes next

    // one entry per slot
    logic        cpu_valid;
    logic [16:0] cpu_tag;
    logic [15:0] cpu_data;
    logic        snd_valid;
    logic [14:0] snd_tag;
    logic [15:0] snd_word;

    logic        cpu_match;
    logic        snd_match;
    logic        cpu_miss;
    logic        snd_miss;
    logic        grant_cpu;
    logic        grant_snd;
    logic        fill_cpu;
    logic        fill_snd;
    logic [21:0] cpu_word_addr;
    logic [21:0] snd_word_addr;

    assign cpu_match = (cpu_tag == cpu_addr);
    assign snd_match = (snd_tag == snd_addr);

    // no fetches while the image is being rewritten
    assign cpu_miss = cpu_cs && !downloading && !(cpu_valid && cpu_match);
    assign snd_miss = snd_cs && !downloading && !(snd_valid && snd_match);

    // cpu first unless sound was already passed over
    assign grant_snd = (state == ARB_IDLE) && snd_miss && (!cpu_miss || snd_wait);
    assign grant_cpu = (state == ARB_IDLE) && cpu_miss && !grant_snd;

    assign fill_cpu = (state == ARB_WAIT_DATA) && data_rdy && !owner_snd;
    assign fill_snd = (state == ARB_WAIT_DATA) && data_rdy && owner_snd;

    assign cpu_word_addr = {5'd0, cpu_addr};
    assign snd_word_addr = SND_WORD_BASE + 22'(snd_addr[14:1]);

    assign sdram_req = (state == ARB_WAIT_ACK); // held until acknowledged

    always_ff @(posedge CLK) begin
        if (reset) begin
            state     <= ARB_IDLE;
            owner_snd <= 1'b0;
            snd_wait  <= 1'b0;
            cpu_valid <= 1'b0;
            snd_valid <= 1'b0;
            cpu_ok    <= 1'b0;
            snd_ok    <= 1'b0;
        end else begin
            // ok follows a hit, or the fill of the address still asked for
            cpu_ok <= cpu_cs && !downloading && cpu_match && (cpu_valid || fill_cpu);
            snd_ok <= snd_cs && !downloading && snd_match && (snd_valid || fill_snd);

            snd_wait <= snd_miss && !grant_snd &&
                        (grant_cpu || (state != ARB_IDLE && !owner_snd));

            case (state)
                ARB_IDLE: begin
                    if (grant_cpu || grant_snd) begin
                        state     <= ARB_WAIT_ACK;
                        owner_snd <= grant_snd;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        state <= ARB_WAIT_DATA;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase

            if (downloading) begin
                cpu_valid <= 1'b0;
                snd_valid <= 1'b0;
            end else begin
                if (grant_cpu) begin
                    cpu_valid <= 1'b0; // tag is about to change
                end else if (fill_cpu) begin
                    cpu_valid <= 1'b1;
                end
                if (grant_snd) begin
                    snd_valid <= 1'b0;
                end else if (fill_snd) begin
                    snd_valid <= 1'b1;
                end
            end
        end
    end

    // tags, cached words and the request address
    always_ff @(posedge CLK) begin
        if (grant_cpu) begin
            cpu_tag    <= cpu_addr;
            sdram_addr <= cpu_word_addr;
        end
        if (grant_snd) begin
            snd_tag    <= snd_addr;
            sdram_addr <= snd_word_addr;
        end
        if (fill_cpu) begin
            cpu_data <= data_read;
        end
        if (fill_snd) begin
            snd_word <= data_read;
        end
    end

    assign cpu_dout = cpu_data;
    assign snd_dout = snd_tag[0] ? snd_word[7:0] : snd_word[15:8]; // even byte is high

endmodule

// File: design/prog_writer.sv
// sdram write stage, builds the word write from a download item and holds it until ready
`timescale 1ns/100ps

module prog_writer #(
    parameter int unsigned SND_OFFSET = 'h100000
) (
    input  logic              CLK,
    input  logic              reset,
    input  rom_pkg::dl_item_t item,
    input  logic              downloading,
    input  logic              prog_rdy,
    output rom_pkg::prog_wr_t prog,
    output logic              prog_we
);
    import rom_pkg::*;

    logic [25:0] byte_addr;
    prog_wr_t    next_wr;

    // sound program sits at a fixed byte offset in bank 0
    assign byte_addr = item.offset +
                       ((item.region == REGION_SND) ? 26'(SND_OFFSET) : 26'd0);

    always_comb begin
        next_wr.addr = 22'(byte_addr >> 1);          // byte to word address
        next_wr.data = {2{item.data}};               // lane picked by the mask
        next_wr.mask = item.addr_lsb ? 2'b01 : 2'b10; // even bytes go high
        next_wr.bank = (item.region == REGION_TILE) ? BANK_GFX : BANK_PRG;
    end

    always_ff @(posedge CLK) begin
        if (item.valid) begin
            prog <= next_wr; // a new byte replaces any held write
        end
        if (reset) begin
            prog_we <= 1'b0;
        end else if (item.valid) begin
            prog_we <= 1'b1;
        end else if (prog_rdy || !downloading) begin
            prog_we <= 1'b0; // released by the controller or end of download
        end
    end

endmodule

// File: design/download_decoder.sv
// download decoder, sorts each ioctl byte into a rom region and latches the game select
`timescale 1ns/100ps

module download_decoder #(
    parameter int unsigned CPU_LEN  = 'h40000,
    parameter int unsigned SND_LEN  = 'h8000,
    parameter int unsigned TILE_LEN = 'h200000
) (
    input  logic              CLK,
    input  logic              reset,
    input  logic              ioctl_wr,
    input  logic [25:0]       ioctl_addr,
    input  logic [7:0]        ioctl_dout,
    output rom_pkg::dl_item_t item,
    output logic [7:0]        game
);
    import rom_pkg::*;

    // region bounds in the download stream, byte 0 is the game select
    localparam logic [25:0] CPU_BASE  = 26'd1;
    localparam logic [25:0] SND_BASE  = 26'(1 + CPU_LEN);
    localparam logic [25:0] TILE_BASE = 26'(1 + CPU_LEN + SND_LEN);
    localparam logic [25:0] ROM_END   = 26'(1 + CPU_LEN + SND_LEN + TILE_LEN);

    region_e     addr_region;
    logic [25:0] region_base;
    logic        is_rom;

    always_comb begin
        if (ioctl_addr == 26'd0) begin
            addr_region = REGION_GAME;
            region_base = 26'd0;
        end else if (ioctl_addr < SND_BASE) begin
            addr_region = REGION_CPU;
            region_base = CPU_BASE;
        end else if (ioctl_addr < TILE_BASE) begin
            addr_region = REGION_SND;
            region_base = SND_BASE;
        end else if (ioctl_addr < ROM_END) begin
            addr_region = REGION_TILE;
            region_base = TILE_BASE;
        end else begin
            addr_region = REGION_NONE; // dropped
            region_base = 26'd0;
        end
    end

    // only these three end up in sdram
    assign is_rom = (addr_region == REGION_CPU) || (addr_region == REGION_SND) ||
                    (addr_region == REGION_TILE);

    always_ff @(posedge CLK) begin
        if (ioctl_wr) begin
            item.region   <= addr_region;
            item.offset   <= ioctl_addr - region_base;
            item.addr_lsb <= ioctl_addr[0]; // picks the lane later
            item.data     <= ioctl_dout;
        end
        if (reset) begin
            item.valid <= 1'b0;
            game       <= 8'h00;
        end else begin
            item.valid <= ioctl_wr && is_rom; // single cycle per byte
            if (ioctl_wr && addr_region == REGION_GAME) begin
                game <= ioctl_dout;
            end
        end
    end

endmodule

// File: design/rom_pkg.sv
// rom download and read types shared by the decoder, writer and top level
package rom_pkg;

    // class of a download address
    typedef enum logic [2:0] {
        REGION_GAME = 3'd0, // byte 0 selects the game
        REGION_CPU  = 3'd1, // main cpu program
        REGION_SND  = 3'd2, // sound cpu program
        REGION_TILE = 3'd3, // tile graphics, bank 1
        REGION_NONE = 3'd4  // past the end of the image
    } region_e;

    // one downloaded byte after address decode
    typedef struct packed {
        logic        valid;    // rom byte to be written
        region_e     region;
        logic [25:0] offset;   // byte offset inside the region
        logic        addr_lsb; // lsb of the absolute download address
        logic [7:0]  data;
    } dl_item_t;

    // sdram word write as seen by the controller
    typedef struct packed {
        logic [21:0] addr; // word address
        logic [15:0] data; // byte repeated on both lanes
        logic [1:0]  mask; // 2'b10 upper lane, 2'b01 lower lane
        logic [1:0]  bank;
    } prog_wr_t;

    // sdram banks
    localparam logic [1:0] BANK_PRG = 2'd0; // cpu and sound programs
    localparam logic [1:0] BANK_GFX = 2'd1; // tiles

endpackage
